// File: clct_cfg.svh
`ifndef CLCT_CFG_SVH
`define CLCT_CFG_SVH

// chamber geometry
`define CLCT_NKEYS 16 // key half-strips per chamber
`define CLCT_NLAYERS 6 // cathode layers

// trigger timing and quality
`define CLCT_STRETCH 4 // clocks a hit stays active after it is sampled
`define CLCT_THRESH 3 // fewest layers a pattern needs to make a CLCT
`define CLCT_DEAD 4 // clocks after a CLCT with no new one issued

`endif

// File: clct_pkg.sv
`default_nettype none

`include "clct_cfg.svh"

package clct_pkg;

  // one bit per half-strip of a single layer
  typedef logic [`CLCT_NKEYS-1:0] layer_hits_t;

  // index of a key half-strip
  typedef logic [$clog2(`CLCT_NKEYS)-1:0] key_t;

  // number of layers hit in a pattern, kept 4 bits wide like the tree encoder
  typedef logic [3:0] pri_t;

endpackage

`default_nettype wire

// File: hit_stretcher.sv
`timescale 1ns/1ps
`default_nettype none

`include "clct_cfg.svh"

module hit_stretcher (
  input  wire                    clock,
  input  wire                    rst,
  input  wire clct_pkg::layer_hits_t ly0,
  input  wire clct_pkg::layer_hits_t ly1,
  input  wire clct_pkg::layer_hits_t ly2,
  input  wire clct_pkg::layer_hits_t ly3,
  input  wire clct_pkg::layer_hits_t ly4,
  input  wire clct_pkg::layer_hits_t ly5,
  output clct_pkg::layer_hits_t  st_ly0,
  output clct_pkg::layer_hits_t  st_ly1,
  output clct_pkg::layer_hits_t  st_ly2,
  output clct_pkg::layer_hits_t  st_ly3,
  output clct_pkg::layer_hits_t  st_ly4,
  output clct_pkg::layer_hits_t  st_ly5
);

  localparam int CW = $clog2(`CLCT_STRETCH + 1);

  clct_pkg::layer_hits_t ly [`CLCT_NLAYERS];
  clct_pkg::layer_hits_t st [`CLCT_NLAYERS];
  logic [CW-1:0]         cnt [`CLCT_NLAYERS][`CLCT_NKEYS]; // one down-counter per strip

  assign ly[0] = ly0;
  assign ly[1] = ly1;
  assign ly[2] = ly2;
  assign ly[3] = ly3;
  assign ly[4] = ly4;
  assign ly[5] = ly5;

  always_ff @(posedge clock)
  begin
    for (int l = 0; l < `CLCT_NLAYERS; l++)
    begin
      for (int s = 0; s < `CLCT_NKEYS; s++)
      begin
        if (rst)
          cnt[l][s] <= '0;
        else if (ly[l][s])
          cnt[l][s] <= CW'(`CLCT_STRETCH); // a fresh hit restarts the window
        else if (cnt[l][s] != '0)
          cnt[l][s] <= cnt[l][s] - 1'b1;
      end
    end
  end

  always_comb
  begin
    for (int l = 0; l < `CLCT_NLAYERS; l++)
      for (int s = 0; s < `CLCT_NKEYS; s++)
        st[l][s] = (cnt[l][s] != '0);
  end

  assign st_ly0 = st[0];
  assign st_ly1 = st[1];
  assign st_ly2 = st[2];
  assign st_ly3 = st[3];
  assign st_ly4 = st[4];
  assign st_ly5 = st[5];

endmodule

`default_nettype wire

// File: pattern_finder.sv
`timescale 1ns/1ps
`default_nettype none

`include "clct_cfg.svh"

module pattern_finder (
  input  wire                    clock,
  input  wire                    rst,
  input  wire clct_pkg::layer_hits_t st_ly0,
  input  wire clct_pkg::layer_hits_t st_ly1,
  input  wire clct_pkg::layer_hits_t st_ly2,
  input  wire clct_pkg::layer_hits_t st_ly3,
  input  wire clct_pkg::layer_hits_t st_ly4,
  input  wire clct_pkg::layer_hits_t st_ly5,
  output clct_pkg::pri_t         pri_0,
  output clct_pkg::pri_t         pri_1,
  output clct_pkg::pri_t         pri_2,
  output clct_pkg::pri_t         pri_3,
  output clct_pkg::pri_t         pri_4,
  output clct_pkg::pri_t         pri_5,
  output clct_pkg::pri_t         pri_6,
  output clct_pkg::pri_t         pri_7,
  output clct_pkg::pri_t         pri_8,
  output clct_pkg::pri_t         pri_9,
  output clct_pkg::pri_t         pri_10,
  output clct_pkg::pri_t         pri_11,
  output clct_pkg::pri_t         pri_12,
  output clct_pkg::pri_t         pri_13,
  output clct_pkg::pri_t         pri_14,
  output clct_pkg::pri_t         pri_15
);

  clct_pkg::layer_hits_t  st [`CLCT_NLAYERS];
  logic [`CLCT_NKEYS+1:0] pad [`CLCT_NLAYERS]; // zero strip on both edges
  logic                   match [`CLCT_NKEYS][`CLCT_NLAYERS];
  clct_pkg::pri_t         cnt [`CLCT_NKEYS];
  clct_pkg::pri_t         pri_r [`CLCT_NKEYS];

  assign st[0] = st_ly0;
  assign st[1] = st_ly1;
  assign st[2] = st_ly2;
  assign st[3] = st_ly3;
  assign st[4] = st_ly4;
  assign st[5] = st_ly5;

  // the two middle layers need the key strip itself, the outer four accept a neighbor
  always_comb
  begin
    for (int l = 0; l < `CLCT_NLAYERS; l++)
      pad[l] = {1'b0, st[l], 1'b0};
    for (int k = 0; k < `CLCT_NKEYS; k++)
    begin
      cnt[k] = '0;
      for (int l = 0; l < `CLCT_NLAYERS; l++)
      begin
        if (l == 2 || l == 3)
          match[k][l] = pad[l][k+1];
        else
          match[k][l] = |pad[l][k +: 3];
        cnt[k] = cnt[k] + clct_pkg::pri_t'(match[k][l]);
      end
    end
  end

  always_ff @(posedge clock)
  begin
    for (int k = 0; k < `CLCT_NKEYS; k++)
    begin
      if (rst)
        pri_r[k] <= '0;
      else
        pri_r[k] <= cnt[k];
    end
  end

  assign pri_0  = pri_r[0];
  assign pri_1  = pri_r[1];
  assign pri_2  = pri_r[2];
  assign pri_3  = pri_r[3];
  assign pri_4  = pri_r[4];
  assign pri_5  = pri_r[5];
  assign pri_6  = pri_r[6];
  assign pri_7  = pri_r[7];
  assign pri_8  = pri_r[8];
  assign pri_9  = pri_r[9];
  assign pri_10 = pri_r[10];
  assign pri_11 = pri_r[11];
  assign pri_12 = pri_r[12];
  assign pri_13 = pri_r[13];
  assign pri_14 = pri_r[14];
  assign pri_15 = pri_r[15];

endmodule

`default_nettype wire

// File: tree_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module tree_encoder (
  input  wire clct_pkg::pri_t win_pri_0,
  input  wire clct_pkg::pri_t win_pri_1,
  input  wire clct_pkg::pri_t win_pri_2,
  input  wire clct_pkg::pri_t win_pri_3,
  input  wire clct_pkg::pri_t win_pri_4,
  input  wire clct_pkg::pri_t win_pri_5,
  input  wire clct_pkg::pri_t win_pri_6,
  input  wire clct_pkg::pri_t win_pri_7,
  input  wire clct_pkg::pri_t win_pri_8,
  input  wire clct_pkg::pri_t win_pri_9,
  input  wire clct_pkg::pri_t win_pri_10,
  input  wire clct_pkg::pri_t win_pri_11,
  input  wire clct_pkg::pri_t win_pri_12,
  input  wire clct_pkg::pri_t win_pri_13,
  input  wire clct_pkg::pri_t win_pri_14,
  input  wire clct_pkg::pri_t win_pri_15,
  output clct_pkg::key_t      clct_win_best,
  output clct_pkg::pri_t      clct_pri_best
);

  clct_pkg::pri_t pri_in [16];
  clct_pkg::pri_t pri_s0 [8];
  logic           win_s0 [8];
  clct_pkg::pri_t pri_s1 [4];
  logic [1:0]     win_s1 [4];

  assign pri_in[0]  = win_pri_0;
  assign pri_in[1]  = win_pri_1;
  assign pri_in[2]  = win_pri_2;
  assign pri_in[3]  = win_pri_3;
  assign pri_in[4]  = win_pri_4;
  assign pri_in[5]  = win_pri_5;
  assign pri_in[6]  = win_pri_6;
  assign pri_in[7]  = win_pri_7;
  assign pri_in[8]  = win_pri_8;
  assign pri_in[9]  = win_pri_9;
  assign pri_in[10] = win_pri_10;
  assign pri_in[11] = win_pri_11;
  assign pri_in[12] = win_pri_12;
  assign pri_in[13] = win_pri_13;
  assign pri_in[14] = win_pri_14;
  assign pri_in[15] = win_pri_15;

  // pairwise tree down to four candidates, strict compares keep ties on the lower key
  always_comb
  begin
    for (int i = 0; i < 8; i++)
    begin
      win_s0[i] = (pri_in[2*i+1] > pri_in[2*i]);
      pri_s0[i] = win_s0[i] ? pri_in[2*i+1] : pri_in[2*i];
    end
    for (int j = 0; j < 4; j++)
    begin
      if (pri_s0[2*j+1] > pri_s0[2*j])
      begin
        pri_s1[j] = pri_s0[2*j+1];
        win_s1[j] = {1'b1, win_s0[2*j+1]};
      end
      else
      begin
        pri_s1[j] = pri_s0[2*j];
        win_s1[j] = {1'b0, win_s0[2*j]};
      end
    end
  end

  // parallel 1-of-4 stage on the quarter winners
  always_comb
  begin
    if ((pri_s1[3] > pri_s1[2]) && (pri_s1[3] > pri_s1[1]) && (pri_s1[3] > pri_s1[0]))
    begin
      clct_pri_best = pri_s1[3];
      clct_win_best = {2'd3, win_s1[3]};
    end
    else if ((pri_s1[2] > pri_s1[1]) && (pri_s1[2] > pri_s1[0]))
    begin
      clct_pri_best = pri_s1[2];
      clct_win_best = {2'd2, win_s1[2]};
    end
    else if (pri_s1[1] > pri_s1[0])
    begin
      clct_pri_best = pri_s1[1];
      clct_win_best = {2'd1, win_s1[1]};
    end
    else
    begin
      clct_pri_best = pri_s1[0];
      clct_win_best = {2'd0, win_s1[0]};
    end
  end

endmodule

`default_nettype wire

// File: clct_builder.sv
`timescale 1ns/1ps
`default_nettype none

`include "clct_cfg.svh"

module clct_builder (
  input  wire                 clock,
  input  wire                 rst,
  input  wire clct_pkg::key_t clct_win_best,
  input  wire clct_pkg::pri_t clct_pri_best,
  output logic                clct_vld,
  output clct_pkg::key_t      clct_key,
  output clct_pkg::pri_t      clct_qual
);

  localparam int DW = $clog2(`CLCT_DEAD + 1);

  logic [DW-1:0] dead_cnt;
  logic          fire;

  // a CLCT goes out only outside the dead window and at or above threshold
  assign fire = (dead_cnt == '0) && (clct_pri_best >= clct_pkg::pri_t'(`CLCT_THRESH));

  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      clct_vld  <= 1'b0;
      dead_cnt  <= '0;
      clct_key  <= '0;
      clct_qual <= '0;
    end
    else
    begin
      clct_vld <= fire; // single-cycle pulse, the dead window blocks the next clock
      if (fire)
      begin
        dead_cnt  <= DW'(`CLCT_DEAD);
        clct_key  <= clct_win_best;
        clct_qual <= clct_pri_best;
      end
      else if (dead_cnt != '0)
      begin
        dead_cnt <= dead_cnt - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: clct_finder.sv
`timescale 1ns/1ps
`default_nettype none

module clct_finder (
  input  wire                    clock,
  input  wire                    rst,
  input  wire clct_pkg::layer_hits_t ly0,
  input  wire clct_pkg::layer_hits_t ly1,
  input  wire clct_pkg::layer_hits_t ly2,
  input  wire clct_pkg::layer_hits_t ly3,
  input  wire clct_pkg::layer_hits_t ly4,
  input  wire clct_pkg::layer_hits_t ly5,
  output logic                   clct_vld,
  output clct_pkg::key_t         clct_key,
  output clct_pkg::pri_t         clct_qual
);

  wire clct_pkg::layer_hits_t st_ly0, st_ly1, st_ly2, st_ly3, st_ly4, st_ly5;
  wire clct_pkg::pri_t        pri_0, pri_1, pri_2, pri_3;
  wire clct_pkg::pri_t        pri_4, pri_5, pri_6, pri_7;
  wire clct_pkg::pri_t        pri_8, pri_9, pri_10, pri_11;
  wire clct_pkg::pri_t        pri_12, pri_13, pri_14, pri_15;
  wire clct_pkg::key_t        clct_win_best;
  wire clct_pkg::pri_t        clct_pri_best;

  hit_stretcher u_stretch (
    .clock  (clock),
    .rst    (rst),
    .ly0    (ly0),
    .ly1    (ly1),
    .ly2    (ly2),
    .ly3    (ly3),
    .ly4    (ly4),
    .ly5    (ly5),
    .st_ly0 (st_ly0),
    .st_ly1 (st_ly1),
    .st_ly2 (st_ly2),
    .st_ly3 (st_ly3),
    .st_ly4 (st_ly4),
    .st_ly5 (st_ly5)
  );

  pattern_finder u_pattern (
    .clock  (clock),
    .rst    (rst),
    .st_ly0 (st_ly0),
    .st_ly1 (st_ly1),
    .st_ly2 (st_ly2),
    .st_ly3 (st_ly3),
    .st_ly4 (st_ly4),
    .st_ly5 (st_ly5),
    .pri_0  (pri_0),
    .pri_1  (pri_1),
    .pri_2  (pri_2),
    .pri_3  (pri_3),
    .pri_4  (pri_4),
    .pri_5  (pri_5),
    .pri_6  (pri_6),
    .pri_7  (pri_7),
    .pri_8  (pri_8),
    .pri_9  (pri_9),
    .pri_10 (pri_10),
    .pri_11 (pri_11),
    .pri_12 (pri_12),
    .pri_13 (pri_13),
    .pri_14 (pri_14),
    .pri_15 (pri_15)
  );

  tree_encoder u_tree (
    .win_pri_0     (pri_0),
    .win_pri_1     (pri_1),
    .win_pri_2     (pri_2),
    .win_pri_3     (pri_3),
    .win_pri_4     (pri_4),
    .win_pri_5     (pri_5),
    .win_pri_6     (pri_6),
    .win_pri_7     (pri_7),
    .win_pri_8     (pri_8),
    .win_pri_9     (pri_9),
    .win_pri_10    (pri_10),
    .win_pri_11    (pri_11),
    .win_pri_12    (pri_12),
    .win_pri_13    (pri_13),
    .win_pri_14    (pri_14),
    .win_pri_15    (pri_15),
    .clct_win_best (clct_win_best),
    .clct_pri_best (clct_pri_best)
  );

  clct_builder u_build (
    .clock         (clock),
    .rst           (rst),
    .clct_win_best (clct_win_best),
    .clct_pri_best (clct_pri_best),
    .clct_vld      (clct_vld),
    .clct_key      (clct_key),
    .clct_qual     (clct_qual)
  );

endmodule

`default_nettype wire

// File: clct_finder_tb.sv
`timescale 1ns/1ps
`default_nettype none

module clct_finder_tb;

  localparam int WINDOW = 12; // clocks watched after a case starts
  localparam int IDLE   = 8; // lets stretch and dead time run out

  logic                  clock;
  logic                  rst;
  clct_pkg::layer_hits_t ly0;
  clct_pkg::layer_hits_t ly1;
  clct_pkg::layer_hits_t ly2;
  clct_pkg::layer_hits_t ly3;
  clct_pkg::layer_hits_t ly4;
  clct_pkg::layer_hits_t ly5;
  wire                   clct_vld;
  wire clct_pkg::key_t   clct_key;
  wire clct_pkg::pri_t   clct_qual;

  string       name_q [$];
  int          hold_q [$];
  logic [95:0] mask_q [$]; // layer 5 in the top bits, layer 0 in the bottom bits
  int          npulse_q [$];
  int          key_q [$];
  int          qual_q [$];
  logic        loaded = 1'b0;
  int          n_pass;
  int          n_fail;

  clct_finder dut0 (
    .clock     (clock),
    .rst       (rst),
    .ly0       (ly0),
    .ly1       (ly1),
    .ly2       (ly2),
    .ly3       (ly3),
    .ly4       (ly4),
    .ly5       (ly5),
    .clct_vld  (clct_vld),
    .clct_key  (clct_key),
    .clct_qual (clct_qual)
  );

  initial
  begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  task automatic drive_layers(input logic [95:0] m);
    ly0 = m[15:0];
    ly1 = m[31:16];
    ly2 = m[47:32];
    ly3 = m[63:48];
    ly4 = m[79:64];
    ly5 = m[95:80];
  endtask

  task automatic read_cases();
    int          fd;
    int          n;
    int          hold;
    int          np;
    int          key;
    int          qual;
    string       line;
    string       nm;
    logic [15:0] m [6];
    fd = $fopen("clct_finder_cases.txt", "r");
    if (fd == 0)
    begin
      $display("could not open clct_finder_cases.txt");
      return;
    end
    while (!$feof(fd))
    begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() > 0 && line[0] != "#") // lines starting with # describe the columns
      begin
        n = $sscanf(line, "%s %d %h %h %h %h %h %h %d %d %d", nm, hold,
                    m[0], m[1], m[2], m[3], m[4], m[5], np, key, qual);
        if (n == 11)
        begin
          name_q.push_back(nm);
          hold_q.push_back(hold);
          mask_q.push_back({m[5], m[4], m[3], m[2], m[1], m[0]});
          npulse_q.push_back(np);
          key_q.push_back(key);
          qual_q.push_back(qual);
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic run_case(input int idx);
    int         pulses;
    bit         ok;
    logic [3:0] got_key;
    logic [3:0] got_qual;
    pulses   = 0;
    ok       = 1'b1;
    got_key  = '0;
    got_qual = '0;
    @(negedge clock);
    drive_layers(mask_q[idx]);
    for (int i = 0; i < WINDOW; i++)
    begin
      @(negedge clock);
      if (clct_vld)
      begin
        if (pulses == 0)
        begin
          got_key  = clct_key; // the first pulse carries the result
          got_qual = clct_qual;
        end
        pulses++;
      end
      if (i + 1 >= hold_q[idx])
        drive_layers('0);
    end
    assert (pulses == npulse_q[idx])
    else
    begin
      $display("%s: wrong number of valid pulses, expected %0d but saw %0d",
               name_q[idx], npulse_q[idx], pulses);
      ok = 1'b0;
    end
    if (npulse_q[idx] > 0 && pulses > 0)
    begin
      assert (got_key == key_q[idx])
      else
      begin
        $display("** Error: %s: key expected %0d actual %0d", name_q[idx], key_q[idx], got_key);
        ok = 1'b0;
      end
      assert (got_qual == qual_q[idx])
      else
      begin
        $display("** Error: %s: quality expected %0d actual %0d",
                 name_q[idx], qual_q[idx], got_qual);
        ok = 1'b0;
      end
    end
    repeat (IDLE) @(negedge clock);
    if (ok)
    begin
      n_pass++;
      $display("%-14s ok", name_q[idx]);
    end
    else
    begin
      n_fail++;
      $display("%-14s failed", name_q[idx]);
    end
  endtask

  // watchdog, sized from the number of cases once they are read
  initial
  begin
    wait (loaded);
    repeat (name_q.size() * 20 + 100) @(posedge clock);
    $display("the run timed out before all cases finished");
    $display("TESTS FAILED");
    $finish;
  end

  initial
  begin
    rst    = 1'b1;
    n_pass = 0;
    n_fail = 0;
    drive_layers('0);
    read_cases();
    loaded = 1'b1;
    repeat (2) @(posedge clock);
    @(negedge clock);
    rst = 1'b0;
    if (name_q.size() == 0)
      $display("no test cases were read");
    foreach (name_q[i])
      run_case(i);
    $display("passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0 && name_q.size() > 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: clct_finder_cases.txt
# name hold_clocks ly0 ly1 ly2 ly3 ly4 ly5 (hex masks, bit n = half-strip n)
# then expected valid pulses in the 12-clock window, key and quality (decimal)
full6_k7     1 0080 0080 0080 0080 0080 0080 1 7 6
two_layers   1 0100 0100 0000 0000 0000 0000 0 0 0
one_layer    1 0000 0000 0000 8000 0000 0000 0 0 0
thresh3_k5   1 0020 0000 0020 0000 0020 0000 1 5 3
bend_k9      1 0100 0400 0200 0200 0100 0400 1 9 6
shift_l2_k9  1 0200 0200 0400 0200 0200 0200 1 9 5
split_mid_k8 1 0200 0200 0400 0100 0200 0200 1 8 5
far_mid_k8   1 0200 0200 0800 0800 0200 0200 1 8 4
better_k12   1 1008 1008 1008 1008 1000 1000 1 12 6
tie_k4_k11   1 0810 0810 0810 0810 0810 0810 1 4 6
tie_k2_k3    1 000c 000c 000c 000c 000c 000c 1 2 6
tie_k6_k13   1 2040 2040 2040 2040 2040 2040 1 6 6
edge_k0      1 0001 0001 0001 0001 0001 0001 1 0 6
edge_k15     1 8000 8000 8000 8000 8000 8000 1 15 6
edge_k15_nb  1 4000 4000 8000 8000 4000 4000 1 15 6
no_wrap_k14  1 8000 8000 0001 0001 8000 8000 1 14 4
hold2_k5     2 0020 0020 0020 0020 0020 0020 1 5 6
hold3_k5     3 0020 0020 0020 0020 0020 0020 2 5 6
hold6_k5     6 0020 0020 0020 0020 0020 0020 2 5 6

// File: clct_finder.f
+incdir+.
clct_pkg.sv
hit_stretcher.sv
pattern_finder.sv
tree_encoder.sv
clct_builder.sv
clct_finder.sv
clct_finder_tb.sv
